//--- common/i2c_pkg.sv
package i2c_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    // 7-bit device address
    parameter int address_width = 7;

    // register address and data bytes
    parameter int byte_width = 8;

    // quarter-phase divider count
    parameter int divider_width = 16;

    //////////////////////////////////////////////////////////////////////
    // host side
    //////////////////////////////////////////////////////////////////////

    // read_write 1 selects a register read, 0 a register write
    typedef struct packed {
        logic                      read_write;
        logic [address_width-1:0]  device_address;
        logic [byte_width-1:0]     register_address;
        logic [byte_width-1:0]     write_data;
    } host_command_t;

    // read_data is zero after a write
    typedef struct packed {
        logic [byte_width-1:0]  read_data;
        logic                   nack_error;
    } host_result_t;

    //////////////////////////////////////////////////////////////////////
    // byte engine side
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        op_start,
        op_restart,
        op_stop,
        op_write,
        op_read
    } byte_op_t;

    // send_nack is the level the master leaves on SDA in the read ACK slot
    typedef struct packed {
        byte_op_t               op;
        logic [byte_width-1:0]  data;
        logic                   send_nack;
    } byte_command_t;

    // acked means the target held SDA low in the ACK slot
    typedef struct packed {
        logic [byte_width-1:0]  data;
        logic                   acked;
    } byte_result_t;

endpackage

//--- byte_engine/i2c_byte_engine.sv
`timescale 1ns/100ps

module i2c_byte_engine #(
    parameter int divider_width = i2c_pkg::divider_width
) (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic [divider_width-1:0]    divider,
    input  logic                        byte_req,
    input  i2c_pkg::byte_command_t      byte_command,
    output logic                        byte_ack,
    output i2c_pkg::byte_result_t       byte_result,
    input  logic                        scl_in,
    input  logic                        sda_in,
    output logic                        scl_oe,
    output logic                        sda_oe
);

    localparam int msb = i2c_pkg::byte_width - 1;
    localparam logic [3:0] ack_bit = 4'(i2c_pkg::byte_width);

    typedef enum logic [1:0] {
        eng_idle,
        eng_run,
        eng_done
    } engine_state_t;

    engine_state_t              state;
    logic [divider_width-1:0]   div_latched;
    logic [divider_width-1:0]   div_count;
    logic [1:0]                 phase;
    logic [3:0]                 bit_count;
    logic [msb:0]               shift_reg;
    logic                       acked;
    logic                       is_byte;
    logic                       hold;
    logic                       tick;
    logic                       next_sda;

    assign is_byte = (byte_command.op == i2c_pkg::op_write) ||
                     (byte_command.op == i2c_pkg::op_read);

    // SCL is released in phase 2 for every op but start, so a target
    // holding it low stalls the phase counter here
    assign hold = (state == eng_run) && (phase == 2'd2) &&
                  (byte_command.op != i2c_pkg::op_start) && !scl_in;

    assign tick = (state == eng_run) && !hold && (div_count == div_latched);

    // SDA level for the bit after the current one
    always_comb begin
        if (bit_count == ack_bit - 4'd1) begin
            next_sda = (byte_command.op == i2c_pkg::op_read) && !byte_command.send_nack;
        end else begin
            next_sda = (byte_command.op == i2c_pkg::op_write) && !shift_reg[msb];
        end
    end

    assign byte_ack = (state == eng_done);
    assign byte_result = '{data: shift_reg, acked: acked};

    //////////////////////////////////////////////////////////////////////
    // payload
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (state == eng_idle && byte_req) begin
            div_latched <= divider;
            shift_reg <= byte_command.data;
        end else if (tick && phase == 2'd2 && is_byte) begin
            if (bit_count == ack_bit) begin
                acked <= !sda_in;
            end else begin
                shift_reg <= {shift_reg[msb-1:0], sda_in};
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // control and bus drive
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= eng_idle;
            div_count <= '0;
            phase <= 2'd0;
            bit_count <= 4'd0;
            scl_oe <= 1'b0;
            sda_oe <= 1'b0;
        end else begin
            case (state)
                eng_idle: begin
                    if (byte_req) begin
                        state <= eng_run;
                        div_count <= '0;
                        phase <= 2'd0;
                        bit_count <= 4'd0;
                        case (byte_command.op)
                            i2c_pkg::op_start: begin
                                scl_oe <= 1'b0;
                                sda_oe <= 1'b0;
                            end
                            i2c_pkg::op_stop:  sda_oe <= 1'b1;
                            i2c_pkg::op_write: sda_oe <= !byte_command.data[msb];
                            default:           sda_oe <= 1'b0;
                        endcase
                    end
                end
                eng_run: begin
                    if (hold || tick) begin
                        div_count <= '0;
                    end else begin
                        div_count <= div_count + 1'b1;
                    end
                    if (tick) begin
                        phase <= phase + 2'd1;
                        case (phase)
                            2'd0: begin
                                if (byte_command.op == i2c_pkg::op_start) begin
                                    sda_oe <= 1'b1;
                                end else begin
                                    scl_oe <= 1'b0;
                                end
                            end
                            2'd2: begin
                                // restart leaves both lines released for the start
                                if (byte_command.op == i2c_pkg::op_stop) begin
                                    sda_oe <= 1'b0;
                                end else if (byte_command.op != i2c_pkg::op_restart) begin
                                    scl_oe <= 1'b1;
                                end
                            end
                            2'd3: begin
                                if (is_byte && bit_count != ack_bit) begin
                                    bit_count <= bit_count + 4'd1;
                                    sda_oe <= next_sda;
                                end else begin
                                    state <= eng_done;
                                end
                            end
                            default: begin
                            end
                        endcase
                    end
                end
                default: begin
                    if (!byte_req) begin
                        state <= eng_idle;
                    end
                end
            endcase
        end
    end

endmodule

//--- source/i2c_transaction_sequencer.sv
`timescale 1ns/100ps

module i2c_transaction_sequencer (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic                        host_req,
    input  i2c_pkg::host_command_t      host_command,
    output logic                        host_ack,
    output i2c_pkg::host_result_t       host_result,
    output logic                        byte_req,
    output i2c_pkg::byte_command_t      byte_command,
    input  logic                        byte_ack,
    input  i2c_pkg::byte_result_t       byte_result
);

    typedef enum logic [3:0] {
        seq_idle,
        seq_start,
        seq_addr_w,
        seq_reg,
        seq_data,
        seq_restart,
        seq_start_r,
        seq_addr_r,
        seq_read,
        seq_stop,
        seq_done
    } seq_state_t;

    seq_state_t                         state;
    seq_state_t                         next_step;
    i2c_pkg::host_command_t             command;
    logic [i2c_pkg::byte_width-1:0]     read_data;
    logic                               nack_error;
    logic                               write_step;

    assign host_ack = (state == seq_done);
    assign host_result = '{read_data: read_data, nack_error: nack_error};

    // address, register and data bytes all need the target's ACK
    assign write_step = (state == seq_addr_w) || (state == seq_reg) ||
                        (state == seq_data) || (state == seq_addr_r);

    //////////////////////////////////////////////////////////////////////
    // engine command for the current step
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        byte_command = '{op: i2c_pkg::op_start, data: '0, send_nack: 1'b0};
        case (state)
            seq_addr_w: begin
                byte_command.op = i2c_pkg::op_write;
                byte_command.data = {command.device_address, 1'b0};
            end
            seq_reg: begin
                byte_command.op = i2c_pkg::op_write;
                byte_command.data = command.register_address;
            end
            seq_data: begin
                byte_command.op = i2c_pkg::op_write;
                byte_command.data = command.write_data;
            end
            seq_restart: byte_command.op = i2c_pkg::op_restart;
            seq_addr_r: begin
                byte_command.op = i2c_pkg::op_write;
                byte_command.data = {command.device_address, 1'b1};
            end
            seq_read: begin
                // single byte, so always answered with a NACK
                byte_command.op = i2c_pkg::op_read;
                byte_command.send_nack = 1'b1;
            end
            seq_stop: byte_command.op = i2c_pkg::op_stop;
            default: begin
            end
        endcase
    end

    always_comb begin
        case (state)
            seq_start:   next_step = seq_addr_w;
            seq_addr_w:  next_step = seq_reg;
            seq_reg:     next_step = command.read_write ? seq_restart : seq_data;
            seq_restart: next_step = seq_start_r;
            seq_start_r: next_step = seq_addr_r;
            seq_addr_r:  next_step = seq_read;
            seq_stop:    next_step = seq_done;
            default:     next_step = seq_stop;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // transaction FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= seq_idle;
            byte_req <= 1'b0;
        end else begin
            case (state)
                seq_idle: begin
                    if (host_req) begin
                        state <= seq_start;
                    end
                end
                seq_done: begin
                    if (!host_req) begin
                        state <= seq_idle;
                    end
                end
                default: begin
                    if (!byte_req && !byte_ack) begin
                        byte_req <= 1'b1;
                    end else if (byte_req && byte_ack) begin
                        byte_req <= 1'b0;
                        if (write_step && !byte_result.acked) begin
                            state <= seq_stop;
                        end else begin
                            state <= next_step;
                        end
                    end
                end
            endcase
        end
    end

    // capture and result payload
    always_ff @(posedge clock) begin
        if (state == seq_idle && host_req) begin
            command <= host_command;
            read_data <= '0;
            nack_error <= 1'b0;
        end else if (byte_req && byte_ack) begin
            if (write_step && !byte_result.acked) begin
                nack_error <= 1'b1;
            end
            if (state == seq_read) begin
                read_data <= byte_result.data;
            end
        end
    end

endmodule

//--- source/i2c_master.sv
`timescale 1ns/100ps

module i2c_master #(
    parameter int divider_width = i2c_pkg::divider_width
) (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic [divider_width-1:0]    divider,
    input  logic                        host_req,
    input  i2c_pkg::host_command_t      host_command,
    output logic                        host_ack,
    output i2c_pkg::host_result_t       host_result,
    input  logic                        scl_in,
    input  logic                        sda_in,
    output logic                        scl_oe,
    output logic                        sda_oe
);

    // byte link
    logic                       byte_req;
    logic                       byte_ack;
    i2c_pkg::byte_command_t     byte_command;
    i2c_pkg::byte_result_t      byte_result;

    i2c_transaction_sequencer u_sequencer (
        .clock        (clock),
        .reset_n      (reset_n),
        .host_req     (host_req),
        .host_command (host_command),
        .host_ack     (host_ack),
        .host_result  (host_result),
        .byte_req     (byte_req),
        .byte_command (byte_command),
        .byte_ack     (byte_ack),
        .byte_result  (byte_result)
    );

    i2c_byte_engine #(
        .divider_width (divider_width)
    ) u_byte_engine (
        .clock        (clock),
        .reset_n      (reset_n),
        .divider      (divider),
        .byte_req     (byte_req),
        .byte_command (byte_command),
        .byte_ack     (byte_ack),
        .byte_result  (byte_result),
        .scl_in       (scl_in),
        .sda_in       (sda_in),
        .scl_oe       (scl_oe),
        .sda_oe       (sda_oe)
    );

endmodule

//--- bench/i2c_target_model.sv
`timescale 1ns/100ps

module i2c_target_model #(
    parameter logic [6:0] device_address = 7'h5a
) (
    input  logic    clock,
    input  logic    reset_n,
    input  logic    scl_line,
    input  logic    sda_line,
    output logic    scl_pull,
    output logic    sda_pull
);

    typedef enum logic [2:0] {
        tgt_idle,
        tgt_addr,
        tgt_reg,
        tgt_write,
        tgt_read_ack,
        tgt_read,
        tgt_ignore
    } target_state_t;

    logic [7:0]     registers [256];
    target_state_t  state;
    logic           scl_prev;
    logic           sda_prev;
    logic [3:0]     bit_count;
    logic [7:0]     shift_in;
    logic [7:0]     tx_byte;
    logic [7:0]     reg_pointer;
    int             stretch_left;

    initial begin
        for (int i = 0; i < 256; i++) begin
            registers[i] = 8'(i) ^ 8'h96;
        end
    end

    assign scl_pull = (stretch_left != 0);

    // random stretch after some falling SCL edges
    always @(posedge clock) begin
        if (!reset_n) begin
            stretch_left <= 0;
        end else if (scl_prev && !scl_line && $urandom_range(1, 0) == 1) begin
            stretch_left <= $urandom_range(20, 0);
        end else if (stretch_left != 0) begin
            stretch_left <= stretch_left - 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bit level protocol
    //////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (!reset_n) begin
            state <= tgt_idle;
            scl_prev <= 1'b1;
            sda_prev <= 1'b1;
            bit_count <= 4'd0;
            sda_pull <= 1'b0;
        end else begin
            scl_prev <= scl_line;
            sda_prev <= sda_line;
            if (scl_prev && scl_line && sda_prev && !sda_line) begin
                // start or repeated start
                state <= tgt_addr;
                bit_count <= 4'd0;
                sda_pull <= 1'b0;
            end else if (scl_prev && scl_line && !sda_prev && sda_line) begin
                state <= tgt_idle;
                sda_pull <= 1'b0;
            end else if (!scl_prev && scl_line) begin
                if (bit_count < 4'd8) begin
                    shift_in <= {shift_in[6:0], sda_line};
                end
                bit_count <= bit_count + 4'd1;
            end else if (scl_prev && !scl_line) begin
                if (bit_count == 4'd8) begin
                    sda_pull <= 1'b0;
                    case (state)
                        tgt_addr: begin
                            if (shift_in[7:1] == device_address) begin
                                sda_pull <= 1'b1;
                                state <= shift_in[0] ? tgt_read_ack : tgt_reg;
                            end else begin
                                state <= tgt_ignore;
                            end
                        end
                        tgt_reg: begin
                            reg_pointer <= shift_in;
                            sda_pull <= 1'b1;
                            state <= tgt_write;
                        end
                        tgt_write: begin
                            registers[reg_pointer] <= shift_in;
                            reg_pointer <= reg_pointer + 8'd1;
                            sda_pull <= 1'b1;
                        end
                        default: begin
                        end
                    endcase
                end else if (bit_count == 4'd9) begin
                    bit_count <= 4'd0;
                    sda_pull <= 1'b0;
                    if (state == tgt_read_ack) begin
                        // MSB goes out right after the address ACK
                        tx_byte <= registers[reg_pointer];
                        sda_pull <= !registers[reg_pointer][7];
                        state <= tgt_read;
                    end else if (state == tgt_read) begin
                        state <= tgt_ignore;
                    end
                end else if (state == tgt_read && bit_count != 4'd0) begin
                    sda_pull <= !tx_byte[6];
                    tx_byte <= {tx_byte[6:0], 1'b0};
                end
            end
        end
    end

endmodule

//--- bench/tb_i2c_master.sv
`timescale 1ns/100ps

module tb_i2c_master;

    localparam int divider_width = i2c_pkg::divider_width;
    localparam int random_count = 200;
    localparam int directed_count = 4;
    localparam int max_divider = 6;
    localparam int max_stretch = 20;
    localparam logic [6:0] target_address = 7'h5a;
    // 40 bit periods of four phases covers a full register read
    localparam longint timeout_ns = longint'(random_count + directed_count) * 40 * 4
                                    * (max_divider + 1 + max_stretch) * 40 + 1_000_000;

    logic                       clock;
    logic                       reset_n;
    logic [divider_width-1:0]   divider;
    logic                       host_req;
    i2c_pkg::host_command_t     host_command;
    logic                       host_ack;
    i2c_pkg::host_result_t      host_result;
    logic                       scl_oe;
    logic                       sda_oe;
    logic                       scl_pull;
    logic                       sda_pull;
    logic                       scl_line;
    logic                       sda_line;
    logic [7:0]                 model [256];

    // open-drain lines with pull-ups
    assign scl_line = !(scl_oe || scl_pull);
    assign sda_line = !(sda_oe || sda_pull);

    always #20 clock = ~clock;

    i2c_master #(
        .divider_width (divider_width)
    ) u_dut (
        .clock        (clock),
        .reset_n      (reset_n),
        .divider      (divider),
        .host_req     (host_req),
        .host_command (host_command),
        .host_ack     (host_ack),
        .host_result  (host_result),
        .scl_in       (scl_line),
        .sda_in       (sda_line),
        .scl_oe       (scl_oe),
        .sda_oe       (sda_oe)
    );

    i2c_target_model #(
        .device_address (target_address)
    ) u_target (
        .clock    (clock),
        .reset_n  (reset_n),
        .scl_line (scl_line),
        .sda_line (sda_line),
        .scl_pull (scl_pull),
        .sda_pull (sda_pull)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error at time %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic run_transaction(input logic read_write, input logic [6:0] device,
                                   input logic [7:0] reg_address, input logic [7:0] data,
                                   input int div_value);
        logic [7:0] expected_data;
        logic       expected_nack;
        logic [8:0] held_result;
        int         extra;
        expected_nack = (device != target_address);
        expected_data = 8'h00;
        if (!expected_nack && read_write) begin
            expected_data = model[reg_address];
        end
        @(posedge clock);
        divider <= divider_width'(div_value);
        host_command <= '{read_write: read_write, device_address: device,
                          register_address: reg_address, write_data: data};
        host_req <= 1'b1;
        @(posedge clock);
        while (!host_ack) begin
            @(posedge clock);
        end
        check_value("host_result.read_data", 32'(expected_data), 32'(host_result.read_data));
        check_value("host_result.nack_error", 32'(expected_nack), 32'(host_result.nack_error));
        held_result = host_result;
        // host keeps req high a little longer
        extra = $urandom_range(6, 0);
        repeat (extra) begin
            @(posedge clock);
            check_value("host_ack", 32'd1, 32'(host_ack));
            check_value("host_result", 32'(held_result), 32'(host_result));
        end
        host_req <= 1'b0;
        @(posedge clock);
        while (host_ack) begin
            @(posedge clock);
        end
        if (!expected_nack && !read_write) begin
            model[reg_address] = data;
        end
    endtask

    task automatic run_random();
        logic [6:0] device;
        device = target_address;
        if ($urandom_range(7, 0) == 0) begin
            device = 7'($urandom);
            if (device == target_address) begin
                device = device ^ 7'h01;
            end
        end
        run_transaction(1'($urandom), device, 8'($urandom), 8'($urandom),
                        $urandom_range(max_divider, 1));
    endtask

    task automatic compare_registers();
        for (int i = 0; i < 256; i++) begin
            check_value($sformatf("u_target.registers[%0d]", i), 32'(model[i]),
                        32'(u_target.registers[i]));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h3b4c80e2));
        clock = 1'b0;
        reset_n = 1'b0;
        host_req = 1'b0;
        divider = '0;
        host_command = '0;
        for (int i = 0; i < 256; i++) begin
            model[i] = 8'(i) ^ 8'h96;
        end
        repeat (3) @(posedge clock);
        reset_n <= 1'b1;
        repeat (2) @(posedge clock);
        check_value("scl_oe", 32'd0, 32'(scl_oe));
        check_value("sda_oe", 32'd0, 32'(sda_oe));
        check_value("host_ack", 32'd0, 32'(host_ack));
        // write then read back
        run_transaction(1'b0, target_address, 8'h3c, 8'hc3, 2);
        run_transaction(1'b1, target_address, 8'h3c, 8'h00, 2);
        // wrong device leaves registers alone
        run_transaction(1'b0, 7'h21, 8'h3c, 8'h55, 3);
        compare_registers();
        run_transaction(1'b1, target_address, 8'h3c, 8'h00, 1);
        repeat (random_count) begin
            run_random();
        end
        compare_registers();
        $display("Finished with no errors");
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Timeout: the transactions did not complete within %0d ns", timeout_ns);
        $display("Finished with errors");
        $fatal(1);
    end

endmodule

//--- sources.f
common/i2c_pkg.sv
byte_engine/i2c_byte_engine.sv
source/i2c_transaction_sequencer.sv
source/i2c_master.sv
bench/i2c_target_model.sv
bench/tb_i2c_master.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_i2c_master
LOG ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT = Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the simulation into $(LOG), check for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Overridable: VERILATOR TOP LOG BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sources.f
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
